// File: include/ooo_config.svh
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// --------------------------------------------------
// Datapath
// --------------------------------------------------

// Width of one data word
`define OOO_XLEN 32

// Rename tag width, one tag per physical register
`define OOO_TAG_BITS 6

// --------------------------------------------------
// Scheduling
// --------------------------------------------------

`define OOO_RS_SIZE 8     // Records per reservation station

`define OOO_MUL_STAGES 2  // Multiplier latency in cycles

`endif

// File: rtl/ooo_pkg.sv
`include "ooo_config.svh"

package ooo_pkg;

  typedef logic [`OOO_XLEN-1:0] xlen_t;
  typedef logic [`OOO_TAG_BITS-1:0] rrn_t;
  typedef logic [3:0] func_t;

  // Function codes 0 to 9 map onto these in order
  typedef enum logic [3:0] {
    ADD     = 4'd0,
    SUB     = 4'd1,
    AND     = 4'd2,
    OR      = 4'd3,
    XOR     = 4'd4,
    SLL     = 4'd5,
    SRL     = 4'd6,
    SLT     = 4'd7,
    MUL     = 4'd8,
    MULH    = 4'd9,
    UNKNOWN = 4'd15
  } instr_name_e;

  typedef enum logic {
    ST_ALU,
    ST_MUL
  } st_type_e;

  typedef struct packed {
    logic valid;
    func_t func;
    rrn_t src_1;
    rrn_t src_2;
    rrn_t rrn;
    logic use_imm;
    xlen_t immediate;
    logic tag;  // Speculative
  } issue_slot_t;

  typedef struct packed {
    xlen_t data_1;
    xlen_t data_2;
    rrn_t src_1;
    rrn_t src_2;
    logic valid_1;
    logic valid_2;
    rrn_t rrn;
    logic tag;
    instr_name_e instr_name;
  } station_entry_t;

  typedef struct packed {
    logic valid;
    station_entry_t entry;
  } station_write_t;

  typedef struct packed {
    logic valid;
    xlen_t data_1;
    xlen_t data_2;
    rrn_t rrn;
    logic tag;
    instr_name_e instr_name;
  } feed_t;

  typedef struct packed {
    logic valid;
    rrn_t rrn;
    xlen_t result;
  } cdb_t;

  typedef struct packed {
    logic valid;
    rrn_t rrn;
  } alloc_t;

endpackage

// File: rtl/issue_decode.sv
`timescale 1ns/1ps

module issue_decode (
  input  logic                    global_bus,
  input  logic                    reset,
  input  ooo_pkg::issue_slot_t    issue [2],
  input  ooo_pkg::cdb_t           cdb [2],
  output ooo_pkg::rrn_t           rf_rrn [4],
  input  ooo_pkg::xlen_t          rf_data [4],
  input  logic                    rf_ready [4],
  output ooo_pkg::alloc_t         alloc [2],
  output ooo_pkg::station_write_t alu_write [2],
  output ooo_pkg::station_write_t mul_write [2]
);

  ooo_pkg::instr_name_e name [2];
  ooo_pkg::st_type_e st_type [2];
  ooo_pkg::station_entry_t entry [2];
  logic [1:0] keep;

  // CDB value wins over the register file
  function automatic void lookup(
    input  ooo_pkg::rrn_t  src,
    input  ooo_pkg::xlen_t rf_value,
    input  logic           rf_valid,
    input  ooo_pkg::cdb_t  lanes [2],
    output ooo_pkg::xlen_t data,
    output logic           valid
  );
    data  = rf_value;
    valid = rf_valid;
    for (int l = 0; l < 2; l++) begin
      if (lanes[l].valid && lanes[l].rrn == src) begin
        data  = lanes[l].result;
        valid = 1'b1;
      end
    end
  endfunction

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      rf_rrn[2*s]   = issue[s].src_1;
      rf_rrn[2*s+1] = issue[s].src_2;
      if (issue[s].func <= 4'd9) begin
        name[s] = ooo_pkg::instr_name_e'(issue[s].func);
      end else begin
        name[s] = ooo_pkg::UNKNOWN;  // Dropped below
      end
      st_type[s] = (name[s] == ooo_pkg::MUL || name[s] == ooo_pkg::MULH) ?
                   ooo_pkg::ST_MUL : ooo_pkg::ST_ALU;
      keep[s] = issue[s].valid && name[s] != ooo_pkg::UNKNOWN;

      entry[s].src_1      = issue[s].src_1;
      entry[s].src_2      = issue[s].src_2;
      entry[s].rrn        = issue[s].rrn;
      entry[s].tag        = issue[s].tag;
      entry[s].instr_name = name[s];
      lookup(issue[s].src_1, rf_data[2*s], rf_ready[2*s], cdb,
             entry[s].data_1, entry[s].valid_1);
      lookup(issue[s].src_2, rf_data[2*s+1], rf_ready[2*s+1], cdb,
             entry[s].data_2, entry[s].valid_2);
      if (issue[s].use_imm) begin
        entry[s].data_2  = issue[s].immediate;
        entry[s].valid_2 = 1'b1;
      end

      alloc[s].valid = keep[s];
      alloc[s].rrn   = issue[s].rrn;
    end

    // Slot 0 result is not in the register file yet
    if (keep[0] && issue[1].src_1 == issue[0].rrn) begin
      entry[1].valid_1 = 1'b0;
    end
    if (keep[0] && !issue[1].use_imm && issue[1].src_2 == issue[0].rrn) begin
      entry[1].valid_2 = 1'b0;
    end
  end

  always_ff @(posedge global_bus) begin
    for (int s = 0; s < 2; s++) begin
      alu_write[s].entry <= entry[s];
      mul_write[s].entry <= entry[s];
      if (reset) begin
        alu_write[s].valid <= 1'b0;
        mul_write[s].valid <= 1'b0;
      end else begin
        alu_write[s].valid <= keep[s] && st_type[s] == ooo_pkg::ST_ALU;
        mul_write[s].valid <= keep[s] && st_type[s] == ooo_pkg::ST_MUL;
      end
    end
  end

endmodule

// File: rtl/reservation_station.sv
`timescale 1ns/1ps
`include "ooo_config.svh"

module reservation_station #(
  parameter int SIZE = `OOO_RS_SIZE
) (
  input  logic                    global_bus,
  input  logic                    reset,
  input  logic                    delete_tag,
  input  ooo_pkg::station_write_t write [2],
  input  ooo_pkg::cdb_t           cdb [2],
  output ooo_pkg::feed_t          feed,
  output logic                    full
);

  localparam int CNT_BITS = $clog2(SIZE + 1);
  localparam int IDX_BITS = $clog2(SIZE);

  // Index 0 holds the oldest record
  ooo_pkg::station_entry_t records [SIZE];
  ooo_pkg::station_entry_t records_next [SIZE];
  logic [CNT_BITS-1:0] count;
  logic [CNT_BITS-1:0] count_next;
  logic sel_found;
  logic [IDX_BITS-1:0] sel_idx;
  ooo_pkg::feed_t feed_next;

  // Capture a result for any operand still waiting on its tag
  function automatic ooo_pkg::station_entry_t wake(
    input ooo_pkg::station_entry_t e,
    input ooo_pkg::cdb_t           lanes [2]
  );
    ooo_pkg::station_entry_t r;
    r = e;
    for (int l = 0; l < 2; l++) begin
      if (!r.valid_1 && lanes[l].valid && lanes[l].rrn == r.src_1) begin
        r.data_1  = lanes[l].result;
        r.valid_1 = 1'b1;
      end
      if (!r.valid_2 && lanes[l].valid && lanes[l].rrn == r.src_2) begin
        r.data_2  = lanes[l].result;
        r.valid_2 = 1'b1;
      end
    end
    return r;
  endfunction

  // --------------------------------------------------
  // Oldest ready record
  // --------------------------------------------------

  always_comb begin
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int i = SIZE - 1; i >= 0; i--) begin
      if (i < int'(count) && records[i].valid_1 && records[i].valid_2) begin
        sel_found = 1'b1;
        sel_idx   = IDX_BITS'(i);
      end
    end

    feed_next.valid      = sel_found && !(delete_tag && records[sel_idx].tag);
    feed_next.data_1     = records[sel_idx].data_1;
    feed_next.data_2     = records[sel_idx].data_2;
    feed_next.rrn        = records[sel_idx].rrn;
    feed_next.tag        = records[sel_idx].tag;
    feed_next.instr_name = records[sel_idx].instr_name;
  end

  // --------------------------------------------------
  // Compaction, squash and append
  // --------------------------------------------------

  always_comb begin
    int k;
    k = 0;
    records_next = records;
    for (int i = 0; i < SIZE; i++) begin
      if (i < int'(count) &&
          !(sel_found && i == int'(sel_idx)) &&
          !(delete_tag && records[i].tag)) begin
        records_next[k] = wake(records[i], cdb);
        k++;
      end
    end
    // Slot 0 first to keep age order
    for (int w = 0; w < 2; w++) begin
      if (write[w].valid && !(delete_tag && write[w].entry.tag) && k < SIZE) begin
        records_next[k] = wake(write[w].entry, cdb);
        k++;
      end
    end
    count_next = CNT_BITS'(k);
  end

  always_ff @(posedge global_bus) begin
    records <= records_next;
    if (reset) begin
      count      <= '0;
      feed.valid <= 1'b0;
    end else begin
      count <= count_next;
      feed  <= feed_next;
    end
  end

  assign full = count > CNT_BITS'(SIZE - 2);  // Fewer than two free

endmodule

// File: rtl/alu_exec.sv
`timescale 1ns/1ps

module alu_exec (
  input  logic           global_bus,
  input  logic           reset,
  input  logic           delete_tag,
  input  ooo_pkg::feed_t feed,
  output ooo_pkg::cdb_t  result
);

  ooo_pkg::xlen_t value;
  ooo_pkg::cdb_t result_q;
  logic tag_q;

  always_comb begin
    case (feed.instr_name)
      ooo_pkg::ADD: value = feed.data_1 + feed.data_2;
      ooo_pkg::SUB: value = feed.data_1 - feed.data_2;
      ooo_pkg::AND: value = feed.data_1 & feed.data_2;
      ooo_pkg::OR:  value = feed.data_1 | feed.data_2;
      ooo_pkg::XOR: value = feed.data_1 ^ feed.data_2;
      ooo_pkg::SLL: value = feed.data_1 << feed.data_2[4:0];
      ooo_pkg::SRL: value = feed.data_1 >> feed.data_2[4:0];
      ooo_pkg::SLT: value = ooo_pkg::xlen_t'($signed(feed.data_1) < $signed(feed.data_2));
      default:      value = '0;
    endcase
  end

  always_ff @(posedge global_bus) begin
    result_q.rrn    <= feed.rrn;
    result_q.result <= value;
    tag_q           <= feed.tag;
    if (reset) begin
      result_q.valid <= 1'b0;
    end else begin
      result_q.valid <= feed.valid && !(delete_tag && feed.tag);
    end
  end

  // Result register is the last place a squash can reach
  always_comb begin
    result       = result_q;
    result.valid = result_q.valid && !(delete_tag && tag_q);
  end

endmodule

// File: rtl/mul_exec.sv
`timescale 1ns/1ps
`include "ooo_config.svh"

module mul_exec (
  input  logic           global_bus,
  input  logic           reset,
  input  logic           delete_tag,
  input  ooo_pkg::feed_t feed,
  output ooo_pkg::cdb_t  result
);

  localparam int STAGES = `OOO_MUL_STAGES;
  localparam int XLEN   = `OOO_XLEN;

  typedef struct packed {
    logic tag;
    logic high;  // MULH
    ooo_pkg::rrn_t rrn;
    logic [2*XLEN-1:0] product;
  } mul_stage_t;

  logic [STAGES-1:0] stage_valid;
  mul_stage_t stage [STAGES];
  logic signed [2*XLEN-1:0] product;

  assign product = $signed(feed.data_1) * $signed(feed.data_2);

  always_ff @(posedge global_bus) begin
    stage[0].tag     <= feed.tag;
    stage[0].high    <= feed.instr_name == ooo_pkg::MULH;
    stage[0].rrn     <= feed.rrn;
    stage[0].product <= product;
    for (int s = 1; s < STAGES; s++) begin
      stage[s] <= stage[s-1];
    end
    if (reset) begin
      stage_valid <= '0;
    end else begin
      stage_valid[0] <= feed.valid && !(delete_tag && feed.tag);
      for (int s = 1; s < STAGES; s++) begin
        stage_valid[s] <= stage_valid[s-1] && !(delete_tag && stage[s-1].tag);
      end
    end
  end

  always_comb begin
    result.valid  = stage_valid[STAGES-1] && !(delete_tag && stage[STAGES-1].tag);
    result.rrn    = stage[STAGES-1].rrn;
    result.result = stage[STAGES-1].high ? stage[STAGES-1].product[2*XLEN-1:XLEN] :
                                           stage[STAGES-1].product[XLEN-1:0];
  end

endmodule

// File: rtl/writeback_stage.sv
`timescale 1ns/1ps
`include "ooo_config.svh"

module writeback_stage (
  input  logic            global_bus,
  input  logic            reset,
  input  ooo_pkg::cdb_t   alu_result,
  input  ooo_pkg::cdb_t   mul_result,
  input  ooo_pkg::alloc_t alloc [2],
  input  ooo_pkg::rrn_t   rf_rrn [4],
  output ooo_pkg::xlen_t  rf_data [4],
  output logic            rf_ready [4],
  output ooo_pkg::cdb_t   cdb [2]
);

  localparam int REGS = 1 << `OOO_TAG_BITS;

  ooo_pkg::xlen_t regs [REGS];
  logic [REGS-1:0] ready;

  always_ff @(posedge global_bus) begin
    if (reset) begin
      cdb[0].valid <= 1'b0;
      cdb[1].valid <= 1'b0;
      ready        <= '1;
      for (int r = 0; r < REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      cdb[0] <= alu_result;  // Lane 0
      cdb[1] <= mul_result;  // Lane 1
      if (alu_result.valid) begin
        regs[alu_result.rrn]  <= alu_result.result;
        ready[alu_result.rrn] <= 1'b1;
      end
      if (mul_result.valid) begin
        regs[mul_result.rrn]  <= mul_result.result;
        ready[mul_result.rrn] <= 1'b1;
      end
      // Allocation comes last and wins
      for (int a = 0; a < 2; a++) begin
        if (alloc[a].valid) ready[alloc[a].rrn] <= 1'b0;
      end
    end
  end

  always_comb begin
    for (int p = 0; p < 4; p++) begin
      rf_data[p]  = regs[rf_rrn[p]];
      rf_ready[p] = ready[rf_rrn[p]];
    end
  end

endmodule

// File: rtl/ooo_cluster.sv
`timescale 1ns/1ps
`include "ooo_config.svh"

module ooo_cluster (
  input  logic                 global_bus,
  input  logic                 reset,
  input  logic                 delete_tag,
  input  ooo_pkg::issue_slot_t issue [2],
  output ooo_pkg::cdb_t        cdb [2],
  output logic                 alu_full,
  output logic                 mul_full
);

  ooo_pkg::rrn_t rf_rrn [4];
  ooo_pkg::xlen_t rf_data [4];
  logic rf_ready [4];
  ooo_pkg::alloc_t alloc [2];
  ooo_pkg::station_write_t alu_write [2];
  ooo_pkg::station_write_t mul_write [2];
  ooo_pkg::feed_t alu_feed;
  ooo_pkg::feed_t mul_feed;
  ooo_pkg::cdb_t alu_result;
  ooo_pkg::cdb_t mul_result;

  issue_decode i_issue_decode (
    .global_bus(global_bus),
    .reset     (reset),
    .issue     (issue),
    .cdb       (cdb),
    .rf_rrn    (rf_rrn),
    .rf_data   (rf_data),
    .rf_ready  (rf_ready),
    .alloc     (alloc),
    .alu_write (alu_write),
    .mul_write (mul_write)
  );

  // --------------------------------------------------
  // Stations and execute units
  // --------------------------------------------------

  reservation_station #(.SIZE(`OOO_RS_SIZE)) i_alu_station (
    .global_bus(global_bus),
    .reset     (reset),
    .delete_tag(delete_tag),
    .write     (alu_write),
    .cdb       (cdb),
    .feed      (alu_feed),
    .full      (alu_full)
  );

  reservation_station #(.SIZE(`OOO_RS_SIZE)) i_mul_station (
    .global_bus(global_bus),
    .reset     (reset),
    .delete_tag(delete_tag),
    .write     (mul_write),
    .cdb       (cdb),
    .feed      (mul_feed),
    .full      (mul_full)
  );

  alu_exec i_alu_exec (
    .global_bus(global_bus),
    .reset     (reset),
    .delete_tag(delete_tag),
    .feed      (alu_feed),
    .result    (alu_result)
  );

  mul_exec i_mul_exec (
    .global_bus(global_bus),
    .reset     (reset),
    .delete_tag(delete_tag),
    .feed      (mul_feed),
    .result    (mul_result)
  );

  writeback_stage i_writeback (
    .global_bus(global_bus),
    .reset     (reset),
    .alu_result(alu_result),
    .mul_result(mul_result),
    .alloc     (alloc),
    .rf_rrn    (rf_rrn),
    .rf_data   (rf_data),
    .rf_ready  (rf_ready),
    .cdb       (cdb)
  );

endmodule

// File: testbench/ooo_cluster_properties.sv
`timescale 1ns/1ps

module ooo_cluster_properties (
  input logic                 global_bus,
  input logic                 reset,
  input ooo_pkg::issue_slot_t issue [2],
  input ooo_pkg::cdb_t        cdb [2],
  input logic                 alu_full,
  input logic                 mul_full
);

  int fail_count = 0;

  // --------------------------------------------------
  // CDB lanes
  // --------------------------------------------------

  a_lane0_tag_known: assert property (@(posedge global_bus) disable iff (reset)
    cdb[0].valid |-> !$isunknown(cdb[0].rrn))
    else begin
      fail_count++;
      $error("lane 0 carries an unknown tag");
    end

  a_lane1_tag_known: assert property (@(posedge global_bus) disable iff (reset)
    cdb[1].valid |-> !$isunknown(cdb[1].rrn))
    else begin
      fail_count++;
      $error("lane 1 carries an unknown tag");
    end

  a_empty_after_reset: assert property (@(posedge global_bus)
    $fell(reset) |-> !alu_full && !mul_full)
    else begin
      fail_count++;
      $error("full flag high right after reset");
    end

  // Issue routing against back-pressure
  a_slot0_not_full: assert property (@(posedge global_bus) disable iff (reset)
    issue[0].valid |-> ((issue[0].func inside {4'd8, 4'd9}) ? !mul_full : !alu_full))
    else begin
      fail_count++;
      $error("slot 0 issued to a full station");
    end

  a_slot1_not_full: assert property (@(posedge global_bus) disable iff (reset)
    issue[1].valid |-> ((issue[1].func inside {4'd8, 4'd9}) ? !mul_full : !alu_full))
    else begin
      fail_count++;
      $error("slot 1 issued to a full station");
    end

endmodule

bind ooo_cluster ooo_cluster_properties i_properties (
  .global_bus(global_bus),
  .reset     (reset),
  .issue     (issue),
  .cdb       (cdb),
  .alu_full  (alu_full),
  .mul_full  (mul_full)
);

// File: testbench/tb_ooo_cluster.sv
`timescale 1ns/1ps
`include "ooo_config.svh"

module tb_ooo_cluster;

  localparam int TAGS        = 1 << `OOO_TAG_BITS;
  localparam int RS_SIZE     = `OOO_RS_SIZE;
  localparam int RUN_CYCLES  = 2000;
  localparam int DRAIN_LIMIT = 500;

  logic global_bus;
  logic reset;
  logic delete_tag;
  ooo_pkg::issue_slot_t issue [2];
  ooo_pkg::cdb_t cdb [2];
  logic alu_full;
  logic mul_full;

  // Reference model state, one entry per tag
  logic [31:0] golden [TAGS];
  bit busy [TAGS];
  bit spec_tag [TAGS];
  bit dead [TAGS];  // Squashed, never completes
  bit on_mul [TAGS];

  integer seed;
  bit squash_pending;
  int alu_done;
  int mul_done;
  int squash_count;
  int alu_last1, alu_last2;
  int mul_last1, mul_last2;

  ooo_cluster i_dut (
    .global_bus(global_bus),
    .reset     (reset),
    .delete_tag(delete_tag),
    .issue     (issue),
    .cdb       (cdb),
    .alu_full  (alu_full),
    .mul_full  (mul_full)
  );

  always #10 global_bus = ~global_bus;

  function automatic int unsigned pick(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, actual, expected);
      fail_run("value mismatch");
    end
  endtask

  function automatic logic [31:0] model_result(input int f, input logic [31:0] a,
                                               input logic [31:0] b);
    logic signed [63:0] prod;
    prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    case (f)
      0: return a + b;
      1: return a - b;
      2: return a & b;
      3: return a | b;
      4: return a ^ b;
      5: return a << b[4:0];
      6: return a >> b[4:0];
      7: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      8: return prod[31:0];
      default: return prod[63:32];
    endcase
  endfunction

  // --------------------------------------------------
  // Monitor and squash bookkeeping
  // --------------------------------------------------

  task automatic sample_cdb();
    int t;
    for (int l = 0; l < 2; l++) begin
      if (cdb[l].valid) begin
        t = cdb[l].rrn;
        if (!busy[t]) begin
          fail_run($sformatf("tag %0d broadcast on lane %0d while not outstanding", t, l));
        end
        check_value($sformatf("cdb[%0d] lane of tag %0d", l, t), l, on_mul[t]);
        check_value($sformatf("cdb[%0d].result tag %0d", l, t), cdb[l].result, golden[t]);
        busy[t] = 1'b0;
        if (l == 0) alu_done++;
        else mul_done++;
      end
    end
  endtask

  // A station only ever holds outstanding work
  task automatic check_full_flags();
    int n_alu;
    int n_mul;
    n_alu = 0;
    n_mul = 0;
    for (int t = 0; t < TAGS; t++) begin
      if (busy[t] && on_mul[t]) n_mul++;
      else if (busy[t]) n_alu++;
    end
    if (alu_full && n_alu < RS_SIZE - 1) begin
      fail_run($sformatf("alu_full high with only %0d ALU instructions outstanding", n_alu));
    end
    if (mul_full && n_mul < RS_SIZE - 1) begin
      fail_run($sformatf("mul_full high with only %0d MUL instructions outstanding", n_mul));
    end
  endtask

  task automatic step_monitor();
    sample_cdb();
    check_full_flags();
    if (i_dut.i_properties.fail_count != 0) begin
      fail_run("an assertion on the cluster ports failed");
    end
    if (squash_pending) begin
      for (int t = 0; t < TAGS; t++) begin
        if (busy[t] && spec_tag[t]) begin
          busy[t] = 1'b0;
          dead[t] = 1'b1;
        end
      end
      squash_pending = 1'b0;
      squash_count++;
    end
  endtask

  function automatic int outstanding();
    int n;
    n = 0;
    for (int t = 0; t < TAGS; t++) n += busy[t];
    return n;
  endfunction

  // Untagged work never waits on a speculative producer
  task automatic pick_source(input bit spec, output ooo_pkg::rrn_t src, output bit found);
    int t;
    found = 1'b0;
    src   = '0;
    for (int i = 0; i < 8 && !found; i++) begin
      t = pick(TAGS);
      if (!dead[t] && (spec || !(busy[t] && spec_tag[t]))) begin
        src   = ooo_pkg::rrn_t'(t);
        found = 1'b1;
      end
    end
  endtask

  task automatic build_slot(input bit allow_alu, input bit allow_mul,
                            output ooo_pkg::issue_slot_t slot, output int unit);
    int f;
    int d;
    bit spec;
    bit ok1, ok2, okd;
    logic [31:0] b;
    slot = '0;
    unit = -1;
    okd  = 1'b0;
    d    = 0;
    if ((!allow_alu && !allow_mul) || pick(4) == 0) return;
    if (allow_mul && (!allow_alu || pick(3) == 0)) f = 8 + pick(2);
    else f = pick(8);
    spec = pick(4) == 0;
    pick_source(spec, slot.src_1, ok1);
    pick_source(spec, slot.src_2, ok2);
    for (int i = 0; i < 16 && !okd; i++) begin
      d = pick(TAGS);
      okd = !busy[d];
    end
    if (!ok1 || !ok2 || !okd) begin
      slot = '0;
      return;
    end
    slot.valid     = 1'b1;
    slot.func      = ooo_pkg::func_t'(f);
    slot.rrn       = ooo_pkg::rrn_t'(d);
    slot.tag       = spec;
    slot.use_imm   = pick(2) == 1;
    slot.immediate = $random(seed);
    b = slot.use_imm ? slot.immediate : golden[slot.src_2];
    golden[d]   = model_result(f, golden[slot.src_1], b);  // Sources read first
    busy[d]     = 1'b1;
    spec_tag[d] = spec;
    dead[d]     = 1'b0;
    on_mul[d]   = f >= 8;
    unit        = on_mul[d];
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    ooo_pkg::issue_slot_t slot;
    int unit;
    int n_alu, n_mul;
    int timer;
    bit ok_alu, ok_mul;
    seed = 32'hb155;
    global_bus = 1'b0;
    reset = 1'b1;
    delete_tag = 1'b0;
    issue[0] = '0;
    issue[1] = '0;
    squash_pending = 1'b0;
    alu_done = 0;
    mul_done = 0;
    squash_count = 0;
    alu_last1 = 0;
    alu_last2 = 0;
    mul_last1 = 0;
    mul_last2 = 0;
    for (int t = 0; t < TAGS; t++) begin
      golden[t] = '0;
      busy[t] = 1'b0;
      spec_tag[t] = 1'b0;
      dead[t] = 1'b0;
      on_mul[t] = 1'b0;
    end
    repeat (16) @(posedge global_bus);
    reset <= 1'b0;

    for (int cycle = 0; cycle < RUN_CYCLES; cycle++) begin
      @(posedge global_bus);
      step_monitor();
      n_alu = 0;
      n_mul = 0;
      // Full flag lags two issue cycles
      ok_alu = !alu_full && alu_last1 == 0 && alu_last2 == 0;
      ok_mul = !mul_full && mul_last1 == 0 && mul_last2 == 0;
      if (cycle > 20 && pick(40) == 0) begin
        delete_tag <= 1'b1;
        issue[0] <= '0;
        issue[1] <= '0;
        squash_pending = 1'b1;
      end else begin
        delete_tag <= 1'b0;
        for (int s = 0; s < 2; s++) begin
          build_slot(ok_alu, ok_mul, slot, unit);
          if (unit == 0) n_alu++;
          if (unit == 1) n_mul++;
          issue[s] <= slot;
        end
      end
      alu_last2 = alu_last1;
      alu_last1 = n_alu;
      mul_last2 = mul_last1;
      mul_last1 = n_mul;
    end

    @(posedge global_bus);
    step_monitor();
    issue[0] <= '0;
    issue[1] <= '0;
    delete_tag <= 1'b0;
    timer = 0;
    while (outstanding() > 0) begin
      @(posedge global_bus);
      step_monitor();
      timer++;
      if (timer > DRAIN_LIMIT) fail_run("drain timed out with tags still outstanding");
    end
    repeat (20) begin
      @(posedge global_bus);
      step_monitor();  // Catches stray broadcasts
    end
    if (alu_done == 0 || mul_done == 0 || squash_count == 0) begin
      fail_run("stimulus never reached an ALU result, a multiplier result or a squash");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

// File: vlog.f
+incdir+include
rtl/ooo_pkg.sv
rtl/issue_decode.sv
rtl/reservation_station.sv
rtl/alu_exec.sv
rtl/mul_exec.sv
rtl/writeback_stage.sv
rtl/ooo_cluster.sv
testbench/ooo_cluster_properties.sv
testbench/tb_ooo_cluster.sv

// File: Bender.yml
package:
  name: ooo_cluster

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/ooo_pkg.sv
      - rtl/issue_decode.sv
      - rtl/reservation_station.sv
      - rtl/alu_exec.sv
      - rtl/mul_exec.sv
      - rtl/writeback_stage.sv
      - rtl/ooo_cluster.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/ooo_cluster_properties.sv
      - testbench/tb_ooo_cluster.sv
